/* verilog/decode_pkg.sv */
// Types and constants for the RV32I decode stage. Only base-ISA opcodes are defined and SYSTEM or MISC-MEM have no entry
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Immediate ALU forms share the register-form code
    typedef enum logic [4:0] {
        UOP_NOP,
        UOP_ADD, UOP_SUB, UOP_SLL, UOP_SLT, UOP_SLTU,
        UOP_XOR, UOP_SRL, UOP_SRA, UOP_OR, UOP_AND,
        UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU,
        UOP_SB, UOP_SH, UOP_SW,
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_JAL, UOP_JALR, UOP_LUI, UOP_AUIPC
    } uop_e;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } fmt_e;

    typedef enum logic [1:0] {
        FWD_NONE,                          // Register file value
        FWD_EX,                            // Execute-stage result
        FWD_WB                             // Writeback data
    } fwd_sel_e;

    typedef struct packed {
        logic lt;                          // Signed rs1 < rs2
        logic ltu;                         // Unsigned rs1 < rs2
        logic eq;
    } cmp_t;

    // Major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

endpackage

/* verilog/instr_decoder.sv */
// Base RV32I only, so SYSTEM, FENCE, M-extension and unknown encodings all come out as illegal with UOP_NOP
`timescale 1ns/1ps

module instr_decoder (
    input  decode_pkg::word_t instr_i,
    output decode_pkg::uop_e  uop_o,
    output decode_pkg::fmt_e  fmt_o,
    output logic              src_a_pc_o,
    output logic              src_b_imm_o,
    output logic              illegal_o
);

    import decode_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        uop_o       = UOP_NOP;
        fmt_o       = FMT_R;
        src_a_pc_o  = 1'b0;
        src_b_imm_o = 1'b1;                // Most forms take the immediate

        case (opcode)
            OPC_OP: begin
                src_b_imm_o = 1'b0;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: uop_o = UOP_ADD;
                        3'b001: uop_o = UOP_SLL;
                        3'b010: uop_o = UOP_SLT;
                        3'b011: uop_o = UOP_SLTU;
                        3'b100: uop_o = UOP_XOR;
                        3'b101: uop_o = UOP_SRL;
                        3'b110: uop_o = UOP_OR;
                        3'b111: uop_o = UOP_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) begin
                        uop_o = UOP_SUB;
                    end else if (funct3 == 3'b101) begin
                        uop_o = UOP_SRA;
                    end
                end
            end
            OPC_OP_IMM: begin
                fmt_o = FMT_I;
                case (funct3)
                    3'b000: uop_o = UOP_ADD;
                    3'b001: uop_o = (funct7 == 7'b0000000) ? UOP_SLL : UOP_NOP;
                    3'b010: uop_o = UOP_SLT;
                    3'b011: uop_o = UOP_SLTU;
                    3'b100: uop_o = UOP_XOR;
                    3'b101: begin
                        if (funct7 == 7'b0000000) begin
                            uop_o = UOP_SRL;
                        end else if (funct7 == 7'b0100000) begin
                            uop_o = UOP_SRA;
                        end
                    end
                    3'b110: uop_o = UOP_OR;
                    3'b111: uop_o = UOP_AND;
                endcase
            end
            OPC_LOAD: begin
                fmt_o = FMT_I;
                case (funct3)
                    3'b000:  uop_o = UOP_LB;
                    3'b001:  uop_o = UOP_LH;
                    3'b010:  uop_o = UOP_LW;
                    3'b100:  uop_o = UOP_LBU;
                    3'b101:  uop_o = UOP_LHU;
                    default: uop_o = UOP_NOP;
                endcase
            end
            OPC_STORE: begin
                fmt_o = FMT_S;
                case (funct3)
                    3'b000:  uop_o = UOP_SB;
                    3'b001:  uop_o = UOP_SH;
                    3'b010:  uop_o = UOP_SW;
                    default: uop_o = UOP_NOP;
                endcase
            end
            OPC_BRANCH: begin
                fmt_o       = FMT_B;
                src_b_imm_o = 1'b0;        // Both sources feed the compare
                case (funct3)
                    3'b000:  uop_o = UOP_BEQ;
                    3'b001:  uop_o = UOP_BNE;
                    3'b100:  uop_o = UOP_BLT;
                    3'b101:  uop_o = UOP_BGE;
                    3'b110:  uop_o = UOP_BLTU;
                    3'b111:  uop_o = UOP_BGEU;
                    default: uop_o = UOP_NOP;
                endcase
            end
            OPC_JAL: begin
                uop_o       = UOP_JAL;
                fmt_o       = FMT_J;
                src_a_pc_o  = 1'b1;
                src_b_imm_o = 1'b0;
            end
            OPC_JALR: begin
                fmt_o = FMT_I;
                uop_o = (funct3 == 3'b000) ? UOP_JALR : UOP_NOP;
            end
            OPC_LUI: begin
                uop_o = UOP_LUI;
                fmt_o = FMT_U;
            end
            OPC_AUIPC: begin
                uop_o      = UOP_AUIPC;
                fmt_o      = FMT_U;
                src_a_pc_o = 1'b1;
            end
            default: uop_o = UOP_NOP;
        endcase

        // No legal encoding maps to NOP
        illegal_o = (uop_o == UOP_NOP);
    end

endmodule

/* verilog/reg_file.sv */
// Two async read ports and one write port with no write-to-read bypass, x0 is hardwired to zero
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  decode_pkg::reg_addr_t rd_addr_a_i,
    input  decode_pkg::reg_addr_t rd_addr_b_i,
    output decode_pkg::word_t     rd_data_a_o,
    output decode_pkg::word_t     rd_data_b_o,
    input  logic                  we_i,
    input  decode_pkg::reg_addr_t wr_addr_i,
    input  decode_pkg::word_t     wr_data_i
);

    import decode_pkg::*;

    word_t regs_q [1:NUM_REGS-1];          // x0 has no storage

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Same-cycle write is not visible here, hazard unit forwards it
    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i];
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i];

endmodule

/* verilog/imm_gen.sv */
// Sign-extended RV32I immediates for I, S, B, U and J formats, and zero for R format
`timescale 1ns/1ps

module imm_gen (
    input  decode_pkg::word_t instr_i,
    input  decode_pkg::fmt_e  fmt_i,
    output decode_pkg::word_t imm_o
);

    import decode_pkg::*;

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (fmt_i)
            FMT_I: begin
                imm_o = {{20{sign}}, instr_i[31:20]};
            end
            FMT_S: begin
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            end
            FMT_B: begin                   // Halfword offset, bit 0 is zero
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            FMT_U: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            FMT_J: begin
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;                // R format carries no immediate
            end
        endcase
    end

endmodule

/* verilog/operand_mux.sv */
// Forwarding and operand selection. The relation flags always compare the forwarded rs1 and rs2 values
`timescale 1ns/1ps

module operand_mux (
    input  decode_pkg::word_t    rs1_data_i,
    input  decode_pkg::word_t    rs2_data_i,
    input  decode_pkg::fwd_sel_e fwd_a_i,
    input  decode_pkg::fwd_sel_e fwd_b_i,
    input  decode_pkg::word_t    ex_fwd_data_i,
    input  decode_pkg::word_t    wb_data_i,
    input  decode_pkg::word_t    pc_i,
    input  decode_pkg::word_t    imm_i,
    input  logic                 src_a_pc_i,
    input  logic                 src_b_imm_i,
    output decode_pkg::word_t    op_a_o,
    output decode_pkg::word_t    op_b_o,
    output decode_pkg::cmp_t     cmp_o
);

    import decode_pkg::*;

    word_t rs1_val;
    word_t rs2_val;

    // Shared by both source ports
    function automatic word_t fwd_pick(fwd_sel_e sel, word_t rf_val, word_t ex_val, word_t wb_val);
        case (sel)
            FWD_EX:  return ex_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign rs1_val = fwd_pick(fwd_a_i, rs1_data_i, ex_fwd_data_i, wb_data_i);
    assign rs2_val = fwd_pick(fwd_b_i, rs2_data_i, ex_fwd_data_i, wb_data_i);

    assign op_a_o = src_a_pc_i ? pc_i : rs1_val;   // JAL and AUIPC use the PC
    assign op_b_o = src_b_imm_i ? imm_i : rs2_val;

    assign cmp_o.lt  = $signed(rs1_val) < $signed(rs2_val);
    assign cmp_o.ltu = rs1_val < rs2_val;
    assign cmp_o.eq  = rs1_val == rs2_val;

endmodule

/* verilog/decode_stage_reg.sv */
// Decode to execute register. Flush wins over stall, and a stalled cycle drops the incoming instruction
`timescale 1ns/1ps

module decode_stage_reg (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  valid_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  decode_pkg::uop_e      uop_i,
    input  decode_pkg::fmt_e      fmt_i,
    input  decode_pkg::word_t     op_a_i,
    input  decode_pkg::word_t     op_b_i,
    input  decode_pkg::cmp_t      cmp_i,
    input  decode_pkg::reg_addr_t rd_i,
    input  decode_pkg::word_t     pc_next_i,
    input  logic                  illegal_i,
    output logic                  ex_valid_o,
    output decode_pkg::uop_e      ex_uop_o,
    output decode_pkg::fmt_e      ex_fmt_o,
    output decode_pkg::word_t     ex_op_a_o,
    output decode_pkg::word_t     ex_op_b_o,
    output decode_pkg::cmp_t      ex_cmp_o,
    output decode_pkg::reg_addr_t ex_rd_o,
    output decode_pkg::word_t     ex_pc_next_o,
    output logic                  ex_illegal_o
);

    import decode_pkg::*;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o   <= 1'b0;
            ex_uop_o     <= UOP_NOP;
            ex_illegal_o <= 1'b0;
        end else if (flush_i) begin
            ex_valid_o   <= 1'b0;
            ex_uop_o     <= UOP_NOP;
            ex_illegal_o <= 1'b0;
        end else if (!stall_i) begin
            ex_valid_o   <= valid_i;       // Bubble when no strobe
            ex_uop_o     <= valid_i ? uop_i : UOP_NOP;
            ex_illegal_o <= valid_i & illegal_i;
        end
    end

    // Payload only moves with a real instruction
    always_ff @(posedge clk_i) begin
        if (valid_i && !stall_i) begin
            ex_fmt_o     <= fmt_i;
            ex_op_a_o    <= op_a_i;
            ex_op_b_o    <= op_b_i;
            ex_cmp_o     <= cmp_i;
            ex_rd_o      <= rd_i;
            ex_pc_next_o <= pc_next_i;
        end
    end

endmodule

/* verilog/decode_stage.sv */
// RV32I decode stage top with one-cycle latency and no back-pressure besides stall, hazard detection is external
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  instr_valid_i,
    input  decode_pkg::word_t     instr_i,
    input  decode_pkg::word_t     pc_i,
    input  decode_pkg::word_t     pc_next_i,
    input  logic                  wb_we_i,
    input  decode_pkg::reg_addr_t wb_rd_i,
    input  decode_pkg::word_t     wb_data_i,
    input  decode_pkg::fwd_sel_e  fwd_a_i,
    input  decode_pkg::fwd_sel_e  fwd_b_i,
    input  decode_pkg::word_t     ex_fwd_data_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    output decode_pkg::reg_addr_t hz_rs1_o,
    output decode_pkg::reg_addr_t hz_rs2_o,
    output logic                  ex_valid_o,
    output decode_pkg::uop_e      ex_uop_o,
    output decode_pkg::fmt_e      ex_fmt_o,
    output decode_pkg::word_t     ex_op_a_o,
    output decode_pkg::word_t     ex_op_b_o,
    output decode_pkg::cmp_t      ex_cmp_o,
    output decode_pkg::reg_addr_t ex_rd_o,
    output decode_pkg::word_t     ex_pc_next_o,
    output logic                  ex_illegal_o
);

    import decode_pkg::*;

    uop_e      uop;
    fmt_e      fmt;
    logic      src_a_pc;
    logic      src_b_imm;
    logic      illegal;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     op_a;
    word_t     op_b;
    cmp_t      cmp;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;

    assign rs1 = instr_i[19:15];
    assign rs2 = instr_i[24:20];
    assign rd  = instr_i[11:7];

    assign hz_rs1_o = rs1;                 // Raw fields for the hazard unit
    assign hz_rs2_o = rs2;

    instr_decoder u_dec (
        .instr_i     (instr_i),
        .uop_o       (uop),
        .fmt_o       (fmt),
        .src_a_pc_o  (src_a_pc),
        .src_b_imm_o (src_b_imm),
        .illegal_o   (illegal)
    );

    reg_file u_rf (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rd_addr_a_i (rs1),
        .rd_addr_b_i (rs2),
        .rd_data_a_o (rs1_data),
        .rd_data_b_o (rs2_data),
        .we_i        (wb_we_i),
        .wr_addr_i   (wb_rd_i),
        .wr_data_i   (wb_data_i)
    );

    imm_gen u_imm (
        .instr_i (instr_i),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    operand_mux u_opmux (
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .fwd_a_i       (fwd_a_i),
        .fwd_b_i       (fwd_b_i),
        .ex_fwd_data_i (ex_fwd_data_i),
        .wb_data_i     (wb_data_i),
        .pc_i          (pc_i),
        .imm_i         (imm),
        .src_a_pc_i    (src_a_pc),
        .src_b_imm_i   (src_b_imm),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .cmp_o         (cmp)
    );

    decode_stage_reg u_sreg (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (instr_valid_i),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .uop_i        (uop),
        .fmt_i        (fmt),
        .op_a_i       (op_a),
        .op_b_i       (op_b),
        .cmp_i        (cmp),
        .rd_i         (rd),
        .pc_next_i    (pc_next_i),
        .illegal_i    (illegal),
        .ex_valid_o   (ex_valid_o),
        .ex_uop_o     (ex_uop_o),
        .ex_fmt_o     (ex_fmt_o),
        .ex_op_a_o    (ex_op_a_o),
        .ex_op_b_o    (ex_op_b_o),
        .ex_cmp_o     (ex_cmp_o),
        .ex_rd_o      (ex_rd_o),
        .ex_pc_next_o (ex_pc_next_o),
        .ex_illegal_o (ex_illegal_o)
    );

endmodule

/* bench/decode_stage_chk.sv */
// Bound into decode_stage, assumes clk_i runs during reset so the reset property gets sampled
`timescale 1ns/1ps

module decode_stage_chk (
    input logic                  clk_i,
    input logic                  arst_n_i,
    input logic                  stall_i,
    input logic                  flush_i,
    input logic                  ex_valid_o,
    input decode_pkg::uop_e      ex_uop_o,
    input decode_pkg::fmt_e      ex_fmt_o,
    input decode_pkg::word_t     ex_op_a_o,
    input decode_pkg::word_t     ex_op_b_o,
    input decode_pkg::cmp_t      ex_cmp_o,
    input decode_pkg::reg_addr_t ex_rd_o,
    input decode_pkg::word_t     ex_pc_next_o,
    input logic                  ex_illegal_o
);

    import decode_pkg::*;

    a_reset_valid: assert property (@(posedge clk_i) !arst_n_i |-> !ex_valid_o)
        else $error("ex_valid_o high while reset is asserted");

    a_flush_bubble: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        flush_i |=> !ex_valid_o)
        else $error("ex_valid_o high after a flush");

    // Whole output bundle holds across a stall
    a_stall_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_i && !flush_i |=> $stable({ex_valid_o, ex_uop_o, ex_fmt_o, ex_op_a_o, ex_op_b_o,
                                         ex_cmp_o, ex_rd_o, ex_pc_next_o, ex_illegal_o}))
        else $error("ex_ outputs changed during a stall");

    a_illegal_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ex_illegal_o |-> ex_valid_o)
        else $error("ex_illegal_o high without ex_valid_o");

endmodule

bind decode_stage decode_stage_chk u_chk (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .stall_i      (stall_i),
    .flush_i      (flush_i),
    .ex_valid_o   (ex_valid_o),
    .ex_uop_o     (ex_uop_o),
    .ex_fmt_o     (ex_fmt_o),
    .ex_op_a_o    (ex_op_a_o),
    .ex_op_b_o    (ex_op_b_o),
    .ex_cmp_o     (ex_cmp_o),
    .ex_rd_o      (ex_rd_o),
    .ex_pc_next_o (ex_pc_next_o),
    .ex_illegal_o (ex_illegal_o)
);

/* bench/tb_decode_stage.sv */
// Reads bench/decode_cases.txt relative to the project root, payload outputs are checked only on rows that are neither flushed nor illegal
`timescale 1ns/1ps

module tb_decode_stage;

    import decode_pkg::*;

    typedef struct packed {
        logic      is_write;
        reg_addr_t wr_rd;
        word_t     wr_data;
        word_t     instr;
        word_t     pc;
        word_t     pc_next;
        fwd_sel_e  fwd_a;
        fwd_sel_e  fwd_b;
        word_t     ex_data;
        word_t     wb_data;
        logic      stall;
        logic      flush;
        uop_e      exp_uop;
        fmt_e      exp_fmt;
        word_t     exp_op_a;
        word_t     exp_op_b;
        cmp_t      exp_cmp;
        reg_addr_t exp_rd;
        logic      exp_illegal;
        logic      exp_valid;
    } case_t;

    logic      clk_i;
    logic      arst_n_i;
    logic      instr_valid_i;
    word_t     instr_i;
    word_t     pc_i;
    word_t     pc_next_i;
    logic      wb_we_i;
    reg_addr_t wb_rd_i;
    word_t     wb_data_i;
    fwd_sel_e  fwd_a_i;
    fwd_sel_e  fwd_b_i;
    word_t     ex_fwd_data_i;
    logic      stall_i;
    logic      flush_i;
    reg_addr_t hz_rs1_o;
    reg_addr_t hz_rs2_o;
    logic      ex_valid_o;
    uop_e      ex_uop_o;
    fmt_e      ex_fmt_o;
    word_t     ex_op_a_o;
    word_t     ex_op_b_o;
    cmp_t      ex_cmp_o;
    reg_addr_t ex_rd_o;
    word_t     ex_pc_next_o;
    logic      ex_illegal_o;

    case_t cases[$];
    int    pass_cnt;
    int    fail_cnt;
    int    errors;                         // Mismatches in the current row
    int    cycles;
    int    cycle_limit;
    word_t held_pc_next;                   // pc_next of the last loaded row

    decode_stage u_dut (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .pc_next_i     (pc_next_i),
        .wb_we_i       (wb_we_i),
        .wb_rd_i       (wb_rd_i),
        .wb_data_i     (wb_data_i),
        .fwd_a_i       (fwd_a_i),
        .fwd_b_i       (fwd_b_i),
        .ex_fwd_data_i (ex_fwd_data_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .hz_rs1_o      (hz_rs1_o),
        .hz_rs2_o      (hz_rs2_o),
        .ex_valid_o    (ex_valid_o),
        .ex_uop_o      (ex_uop_o),
        .ex_fmt_o      (ex_fmt_o),
        .ex_op_a_o     (ex_op_a_o),
        .ex_op_b_o     (ex_op_b_o),
        .ex_cmp_o      (ex_cmp_o),
        .ex_rd_o       (ex_rd_o),
        .ex_pc_next_o  (ex_pc_next_o),
        .ex_illegal_o  (ex_illegal_o)
    );

    always #50 clk_i = ~clk_i;             // 100 ns period

    always @(posedge clk_i) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not reach its end", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_uop(input string name, input uop_e exp, input uop_e act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_fmt(input string name, input fmt_e exp, input fmt_e act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cmp(input string name, input cmp_t exp, input cmp_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Source register fields sit at the same bits in every RV32I format
    function automatic reg_addr_t rs1_field(input word_t instr);
        return instr[19:15];
    endfunction

    function automatic reg_addr_t rs2_field(input word_t instr);
        return instr[24:20];
    endfunction

    task automatic idle_inputs();
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        pc_next_i     = '0;
        wb_we_i       = 1'b0;
        wb_rd_i       = '0;
        wb_data_i     = '0;
        fwd_a_i       = FWD_NONE;
        fwd_b_i       = FWD_NONE;
        ex_fwd_data_i = '0;
        stall_i       = 1'b0;
        flush_i       = 1'b0;
    endtask

    task automatic load_cases();
        int          fd;
        int          code;
        logic        done;
        logic [7:0]  tag;
        logic [31:0] f [0:16];
        logic [8*160-1:0] skip;
        case_t       rec;
        fd = $fopen("bench/decode_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/decode_cases.txt");
            fail_cnt++;
        end else begin
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, " %c", tag);
                rec  = '0;
                if (code != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    code = $fgets(skip, fd);   // Comment line
                end else if (tag == "W") begin
                    code = $fscanf(fd, "%h %h", f[0], f[1]);
                    rec.is_write = 1'b1;
                    rec.wr_rd    = f[0][4:0];
                    rec.wr_data  = f[1];
                    cases.push_back(rec);
                end else if (tag == "D") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                   f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                    if (code != 17) begin
                        $display("Decode row %0d in the case file is incomplete", cases.size());
                        fail_cnt++;
                    end
                    rec.instr       = f[0];
                    rec.pc          = f[1];
                    rec.pc_next     = f[2];
                    rec.fwd_a       = fwd_sel_e'(f[3][1:0]);
                    rec.fwd_b       = fwd_sel_e'(f[4][1:0]);
                    rec.ex_data     = f[5];
                    rec.wb_data     = f[6];
                    rec.stall       = f[7][0];
                    rec.flush       = f[8][0];
                    rec.exp_uop     = uop_e'(f[9][4:0]);
                    rec.exp_fmt     = fmt_e'(f[10][2:0]);
                    rec.exp_op_a    = f[11];
                    rec.exp_op_b    = f[12];
                    rec.exp_cmp     = cmp_t'(f[13][2:0]);
                    rec.exp_rd      = f[14][4:0];
                    rec.exp_illegal = f[15][0];
                    rec.exp_valid   = f[16][0];
                    cases.push_back(rec);
                end else begin
                    $display("Unknown record type in the case file");
                    fail_cnt++;
                    done = 1'b1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_write(input case_t c);
        idle_inputs();
        wb_we_i   = 1'b1;
        wb_rd_i   = c.wr_rd;
        wb_data_i = c.wr_data;
        @(posedge clk_i);
        #5;
        wb_we_i = 1'b0;
        $display("write x%0d = %h applied", c.wr_rd, c.wr_data);
    endtask

    task automatic run_decode(input case_t c, input int idx);
        word_t exp_pc_next;
        instr_valid_i = 1'b1;
        instr_i       = c.instr;
        pc_i          = c.pc;
        pc_next_i     = c.pc_next;
        wb_we_i       = 1'b0;
        fwd_a_i       = c.fwd_a;
        fwd_b_i       = c.fwd_b;
        ex_fwd_data_i = c.ex_data;
        wb_data_i     = c.wb_data;
        stall_i       = c.stall;
        flush_i       = c.flush;
        @(posedge clk_i);
        #5;                                // Registered outputs settled
        errors      = 0;
        exp_pc_next = (c.stall && !c.flush) ? held_pc_next : c.pc_next;
        check_addr("hz_rs1_o", rs1_field(c.instr), hz_rs1_o);   // instr_i still held
        check_addr("hz_rs2_o", rs2_field(c.instr), hz_rs2_o);
        check_bit("ex_valid_o", c.exp_valid, ex_valid_o);
        check_uop("ex_uop_o", c.exp_uop, ex_uop_o);
        check_bit("ex_illegal_o", c.exp_illegal, ex_illegal_o);
        if (!c.flush && !c.exp_illegal) begin
            check_fmt("ex_fmt_o", c.exp_fmt, ex_fmt_o);
            check_word("ex_op_a_o", c.exp_op_a, ex_op_a_o);
            check_word("ex_op_b_o", c.exp_op_b, ex_op_b_o);
            check_cmp("ex_cmp_o", c.exp_cmp, ex_cmp_o);
            check_addr("ex_rd_o", c.exp_rd, ex_rd_o);
            check_word("ex_pc_next_o", exp_pc_next, ex_pc_next_o);
        end
        if (!c.flush) begin
            held_pc_next = exp_pc_next;
        end
        if (errors == 0) begin
            pass_cnt++;
            $display("row %0d decode %h ok", idx, c.instr);
        end else begin
            fail_cnt++;
            $display("row %0d decode %h has %0d mismatches", idx, c.instr, errors);
        end
    endtask

    initial begin
        idle_inputs();
        clk_i        = 1'b0;
        arst_n_i     = 1'b1;
        pass_cnt     = 0;
        fail_cnt     = 0;
        errors       = 0;
        cycles       = 0;
        cycle_limit  = 0;
        held_pc_next = '0;
        load_cases();
        cycle_limit = 4 * cases.size() + 20;
        #1;
        arst_n_i = 1'b0;                   // Falling edge starts the reset
        repeat (2) @(posedge clk_i);
        #5;
        arst_n_i = 1'b1;
        foreach (cases[i]) begin
            if (cases[i].is_write) begin
                run_write(cases[i]);
            end else begin
                run_decode(cases[i], i);
            end
        end
        idle_inputs();
        $display("Decode rows passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* bench/decode_cases.txt */
# W rd value | D instr pc pc_next fwd_a fwd_b ex_data wb_data stall flush, all hex
#   then expected uop fmt op_a op_b cmp(lt ltu eq) rd illegal valid; payload unchecked on flush or illegal rows
W 05 00000025
W 06 ffffff80
D 006280b3 00000100 00000104 0 0 00000000 00000000 0 0 01 0 00000025 ffffff80 2 01 0 1
D 40628133 00000104 00000108 0 0 00000000 00000000 0 0 02 0 00000025 ffffff80 2 02 0 1
D 005321b3 00000108 0000010c 0 0 00000000 00000000 0 0 04 0 ffffff80 00000025 4 03 0 1
D fff2c213 0000010c 00000110 0 0 00000000 00000000 0 0 06 1 00000025 ffffffff 0 04 0 1
D 0082a383 00000110 00000114 0 0 00000000 00000000 0 0 0d 1 00000025 00000008 0 07 0 1
D fe62ae23 00000114 00000118 0 0 00000000 00000000 0 0 12 2 00000025 fffffffc 2 1c 0 1
D 00628863 00000118 00000128 0 0 00000000 00000000 0 0 13 3 00000025 ffffff80 2 10 0 1
D 100000ef 00000200 00000204 0 0 00000000 00000000 0 0 19 5 00000200 00000000 1 01 0 1
D 12345537 00000204 00000208 0 0 00000000 00000000 0 0 1b 4 00000000 12345000 1 0a 0 1
D fffff597 00000300 00000304 0 0 00000000 00000000 0 0 1c 4 00000300 fffff000 1 0b 0 1
D 0062c463 00000304 00000308 1 2 fffffff0 00000010 0 0 15 3 fffffff0 00000010 4 08 0 1
D 0062e463 00000308 0000030c 2 1 fffffff0 00000010 0 0 17 3 00000010 fffffff0 2 08 0 1
W 00 deadbeef
D 000004b3 0000030c 00000310 0 0 00000000 00000000 0 0 01 0 00000000 00000000 1 09 0 1
D 0ff36613 00000310 00000314 0 0 00000000 00000000 0 0 09 1 ffffff80 000000ff 4 0c 0 1
D 0062f6b3 00000314 00000318 0 0 00000000 00000000 1 0 09 1 ffffff80 000000ff 4 0c 0 1
D 0062f6b3 00000314 00000318 0 0 00000000 00000000 1 1 00 0 00000000 00000000 0 00 0 0
D 0062f6b3 00000314 00000318 0 0 00000000 00000000 0 1 00 0 00000000 00000000 0 00 0 0
D 0062f6b3 00000314 00000318 0 0 00000000 00000000 0 0 0a 0 00000025 ffffff80 2 0d 0 1
D 300290f3 00000318 0000031c 0 0 00000000 00000000 0 0 00 0 00000000 00000000 0 00 1 1
D 0ff0000f 0000031c 00000320 0 0 00000000 00000000 0 0 00 0 00000000 00000000 0 00 1 1
D 0000007f 00000320 00000324 0 0 00000000 00000000 0 0 00 0 00000000 00000000 0 00 1 1
D 026280b3 00000324 00000328 0 0 00000000 00000000 0 0 00 0 00000000 00000000 0 00 1 1

/* sim.f */
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/imm_gen.sv
verilog/operand_mux.sv
verilog/decode_stage_reg.sv
verilog/decode_stage.sv
bench/decode_stage_chk.sv
bench/tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decode_stage -f sim.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_decode_stage)
sim_status=$?
printf '%s\n' "$sim_output"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx 'TEST RESULT: PASS'; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
